// ==== src.f ====
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench.
# Any variable can be overridden, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The simulator's own exit status is ignored; the log decides.
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "No pass report in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_dcache.sv ====
// Data cache testbench
`timescale 1ns/1ns

module tb_dcache;

    localparam int          DRIVE_DLY        = 2;
    localparam int          CYCLES_PER_ENTRY = 16;
    localparam logic [63:0] FILL_KEY         = 64'h5a5a_0000_a5a5_ffff;
    localparam logic [63:0] ADDR_L1          = 64'h0000_0000_0000_0408; // Set 1.
    localparam logic [63:0] ADDR_X           = 64'h0000_0000_0001_0010; // Set 2.
    localparam logic [63:0] ADDR_Y           = 64'h0000_0000_0002_0010;
    localparam logic [63:0] ADDR_Z           = 64'h1234_5678_0003_0010;
    localparam logic [63:0] ADDR_A           = 64'h0000_0000_0010_0018; // Set 3.
    localparam logic [63:0] ADDR_B           = 64'h0000_0000_0020_0018;
    localparam logic [63:0] ADDR_C           = 64'hfedc_0000_0030_0018;
    localparam logic [63:0] ADDR_M           = 64'h0000_0000_0000_0b38; // Set 39.
    localparam dcache_pkg::cpu_op_e RD       = dcache_pkg::OP_READ;
    localparam dcache_pkg::cpu_op_e WR       = dcache_pkg::OP_WRITE;

    typedef struct packed {
        dcache_pkg::cpu_op_e op;
        logic [63:0]         addr;
        dcache_pkg::line_t   wdata;
        dcache_pkg::strb_t   strb;
        logic                hit;
        logic                wb;      // Dirty victim expected.
        logic [63:0]         wb_addr;
    } entry_t;

    logic                  clk;
    logic                  reset;
    logic                  cpu_req_valid;
    dcache_pkg::cpu_req_t  cpu_req;
    logic                  cpu_ready;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;
    int                    wb_count;
    int                    refill_count;
    logic [63:0]           last_wb_addr;
    dcache_pkg::line_t     last_wb_data;

    entry_t     stimulus [$];
    logic [7:0] gold_bytes [logic [63:0]];
    int         cycle_count;
    int         cycle_limit;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3), .DRIVE_DLY(DRIVE_DLY)) u_clock_gen (
        .clk     (clk),
        .reset_o (reset)
    );

    tb_mem_model #(.DRIVE_DLY(DRIVE_DLY)) u_mem_model (
        .clk            (clk),
        .mem_req_i      (mem_req),
        .mem_resp_o     (mem_resp),
        .wb_count_o     (wb_count),
        .refill_count_o (refill_count),
        .last_wb_addr_o (last_wb_addr),
        .last_wb_data_o (last_wb_data)
    );

    dcache_top i_dut (
        .clk             (clk),
        .reset_i         (reset),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_i       (cpu_req),
        .cpu_ready_o     (cpu_ready),
        .cpu_resp_o      (cpu_resp),
        .mem_req_o       (mem_req),
        .mem_resp_i      (mem_resp)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic void add_entry(input dcache_pkg::cpu_op_e op, input logic [63:0] addr,
            input dcache_pkg::line_t wdata, input dcache_pkg::strb_t strb, input logic hit,
            input logic wb, input logic [63:0] wb_addr);
        stimulus.push_back('{op, addr, wdata, strb, hit, wb, wb_addr});
    endfunction

    // Golden line from the byte memory. Unwritten bytes follow the fill rule.
    function automatic dcache_pkg::line_t golden_line(input logic [63:0] addr);
        logic [63:0]       base;
        logic [63:0]       fill;
        dcache_pkg::line_t line;
        base = {addr[63:3], 3'b000};
        fill = base ^ FILL_KEY;
        for (int b = 0; b < 8; b++) begin
            if (gold_bytes.exists(base + 64'(b)))
                line[b*8 +: 8] = gold_bytes[base + 64'(b)];
            else
                line[b*8 +: 8] = fill[b*8 +: 8];
        end
        return line;
    endfunction

    function automatic void golden_write(input logic [63:0] addr, input dcache_pkg::line_t wdata,
            input dcache_pkg::strb_t strb);
        logic [63:0] base;
        base = {addr[63:3], 3'b000};
        for (int b = 0; b < 8; b++) begin
            if (strb[b])
                gold_bytes[base + 64'(b)] = wdata[b*8 +: 8];
        end
    endfunction

    function automatic void build_table();
        add_entry(RD, ADDR_L1,         '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_L1 | 64'h4, '0,                     8'h00, 1'b1, 1'b0, '0);
        add_entry(WR, ADDR_L1,         64'h1122_3344_5566_7788, 8'h36, 1'b1, 1'b0, '0);
        add_entry(RD, ADDR_L1,         '0,                     8'h00, 1'b1, 1'b0, '0);
        add_entry(WR, ADDR_X,          64'hdead_beef_0bad_f00d, 8'hf0, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_Y,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_Z,          '0,                     8'h00, 1'b0, 1'b1, ADDR_X);
        add_entry(RD, ADDR_X,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_A,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_B,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_A,          '0,                     8'h00, 1'b1, 1'b0, '0);
        add_entry(RD, ADDR_C,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_A,          '0,                     8'h00, 1'b1, 1'b0, '0);
        add_entry(RD, ADDR_B,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(WR, ADDR_M,          64'h0123_4567_89ab_cdef, 8'hf0, 1'b0, 1'b0, '0);
        add_entry(WR, ADDR_M,          64'hfeed_face_cafe_babe, 8'h0f, 1'b1, 1'b0, '0);
        add_entry(RD, ADDR_M,          '0,                     8'h00, 1'b1, 1'b0, '0);
        add_entry(WR, ADDR_C,          64'h5555_aaaa_3333_cccc, 8'hff, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_A,          '0,                     8'h00, 1'b0, 1'b0, '0);
        add_entry(RD, ADDR_B,          '0,                     8'h00, 1'b0, 1'b1, ADDR_C);
        add_entry(RD, ADDR_C,          '0,                     8'h00, 1'b0, 1'b0, '0);
    endfunction

    task automatic check_reset();
        @(negedge clk);
        while (reset)
            @(negedge clk);
        assert (cpu_ready) else stop_on_error("cpu_ready_o is low after reset.");
        assert (!cpu_resp.valid) else stop_on_error("cpu_resp_o.valid is high after reset.");
        assert (mem_req.cmd == dcache_pkg::MEM_NONE)
            else stop_on_error($sformatf("FAIL mem_req_o.cmd: got %h, expected %h",
                                         mem_req.cmd, dcache_pkg::MEM_NONE));
    endtask

    // ************************************************************************
    // One table entry from request to completion
    // ************************************************************************
    task automatic run_entry(input int idx);
        entry_t               e;
        logic [63:0]          line_addr;
        dcache_pkg::mem_req_t prev_req;
        logic                 prev_waiting;
        logic                 saw_mem;
        logic                 saw_refill;
        logic [63:0]          refill_addr;
        int                   cycles;
        int                   wb_before;
        int                   refill_before;
        e             = stimulus[idx];
        line_addr     = {e.addr[63:3], 3'b000};
        wb_before     = wb_count;
        refill_before = refill_count;
        prev_req      = '0;
        prev_waiting  = 1'b0;
        saw_mem       = 1'b0;
        saw_refill    = 1'b0;
        refill_addr   = '0;
        cycles        = 0;
        cpu_req_valid = 1'b1;
        cpu_req.op    = e.op;
        cpu_req.addr  = e.addr;
        cpu_req.wdata = e.wdata;
        cpu_req.strb  = e.strb;
        @(negedge clk);
        while (!cpu_ready)
            @(negedge clk);
        @(posedge clk); // Accepted here.
        #DRIVE_DLY;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        do begin
            @(negedge clk);
            cycles++;
            if (prev_waiting)
                assert (mem_req == prev_req)
                    else stop_on_error($sformatf("FAIL mem_req_o: got %h, expected %h",
                                                 mem_req, prev_req));
            prev_waiting = (mem_req.cmd != dcache_pkg::MEM_NONE) && !mem_resp.ready;
            prev_req     = mem_req;
            if (mem_req.cmd != dcache_pkg::MEM_NONE)
                saw_mem = 1'b1;
            if (mem_req.cmd == dcache_pkg::MEM_REFILL) begin
                saw_refill  = 1'b1;
                refill_addr = mem_req.addr;
            end
        end while (!cpu_resp.valid);
        if (e.hit) begin
            assert (cycles == 1 && !saw_mem)
                else stop_on_error($sformatf("Entry %0d should hit but took %0d cycles.",
                                             idx, cycles));
        end else begin
            assert (cycles > 1 && saw_refill)
                else stop_on_error($sformatf("Entry %0d should miss but no refill was seen.",
                                             idx));
            assert (refill_addr == line_addr)
                else stop_on_error($sformatf("FAIL mem_req_o.addr: got %h, expected %h",
                                             refill_addr, line_addr));
        end
        if (e.op == dcache_pkg::OP_READ)
            assert (cpu_resp.rdata == golden_line(e.addr))
                else stop_on_error($sformatf("FAIL cpu_resp_o.rdata: got %h, expected %h",
                                             cpu_resp.rdata, golden_line(e.addr)));
        assert (wb_count == wb_before + int'(e.wb))
            else stop_on_error($sformatf("FAIL wb_count: got %h, expected %h",
                                         wb_count, wb_before + int'(e.wb)));
        if (e.wb) begin
            assert (last_wb_addr == e.wb_addr)
                else stop_on_error($sformatf("FAIL mem_req_o.addr: got %h, expected %h",
                                             last_wb_addr, e.wb_addr));
            assert (last_wb_data == golden_line(e.wb_addr))
                else stop_on_error($sformatf("FAIL mem_req_o.wdata: got %h, expected %h",
                                             last_wb_data, golden_line(e.wb_addr)));
        end
        assert (refill_count == refill_before + (e.hit ? 0 : 1))
            else stop_on_error($sformatf("FAIL refill_count: got %h, expected %h",
                                         refill_count, refill_before + (e.hit ? 0 : 1)));
        if (e.op == dcache_pkg::OP_WRITE)
            golden_write(e.addr, e.wdata, e.strb);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            stop_on_error($sformatf("Timeout: table not finished within %0d cycles.",
                                    cycle_limit));
    end

    initial begin
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cycle_count   = 0;
        build_table();
        cycle_limit = stimulus.size() * CYCLES_PER_ENTRY;
        check_reset();
        @(posedge clk);
        #DRIVE_DLY;
        foreach (stimulus[i])
            run_entry(i);
        $display("Finished %0d entries in %0d cycles.", stimulus.size(), cycle_count);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== testbench/tb_mem_model.sv ====
// Backing memory for the line port
`timescale 1ns/1ns

module tb_mem_model #(
    parameter int DRIVE_DLY = 2
) (
    input  logic                  clk,
    input  dcache_pkg::mem_req_t  mem_req_i,
    output dcache_pkg::mem_resp_t mem_resp_o,
    output int                    wb_count_o,
    output int                    refill_count_o,
    output logic [63:0]           last_wb_addr_o,
    output dcache_pkg::line_t     last_wb_data_o
);

    localparam logic [63:0] FILL_KEY = 64'h5a5a_0000_a5a5_ffff;
    localparam int unsigned SEED     = 32'hf130_960b;

    dcache_pkg::line_t    lines [logic [63:0]];
    dcache_pkg::mem_req_t held;
    logic                 busy;
    int unsigned          wait_left;

    // Lines never written back hold the fill pattern.
    function automatic dcache_pkg::line_t read_line(input logic [63:0] addr);
        if (lines.exists(addr))
            return lines[addr];
        return addr ^ FILL_KEY;
    endfunction

    initial begin
        void'($urandom(SEED));
        mem_resp_o     = '0;
        wb_count_o     = 0;
        refill_count_o = 0;
        last_wb_addr_o = '0;
        last_wb_data_o = '0;
        held           = '0;
        busy           = 1'b0;
        wait_left      = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (mem_resp_o.ready) begin // Transfer done at this edge.
                if (held.cmd == dcache_pkg::MEM_WRITEBACK) begin
                    lines[held.addr] = held.wdata;
                    wb_count_o++;
                    last_wb_addr_o = held.addr;
                    last_wb_data_o = held.wdata;
                end else begin
                    refill_count_o++;
                end
                mem_resp_o = '0;
                busy       = 1'b0;
            end
            if (!busy && mem_req_i.cmd != dcache_pkg::MEM_NONE) begin
                busy      = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (busy) begin
                if (wait_left == 0) begin
                    held             = mem_req_i;
                    mem_resp_o.ready = 1'b1;
                    mem_resp_o.rdata = read_line(held.addr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3,
    parameter int DRIVE_DLY    = 2
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset_o = 1'b0; // Released just after the edge, like other inputs.
    end

endmodule

// ==== source/dcache_top.sv ====
// Two-way write-back data cache
`timescale 1ns/1ns

module dcache_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cpu_req_valid_i,
    input  dcache_pkg::cpu_req_t  cpu_req_i,
    output logic                  cpu_ready_o,
    output dcache_pkg::cpu_resp_t cpu_resp_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  dcache_pkg::mem_resp_t mem_resp_i
);

    dcache_pkg::index_t                             index;
    logic                                           tag_we;
    dcache_pkg::way_t                               tag_way;
    dcache_pkg::tag_t                               tag_wtag;
    logic                                           tag_dirty;
    logic                                           lru_we;
    dcache_pkg::way_t                               lru_way;
    dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0]    tag_rd;
    logic [dcache_pkg::NUM_WAYS-1:0]                valid_rd;
    logic [dcache_pkg::NUM_WAYS-1:0]                dirty_rd;
    dcache_pkg::way_t                               lru_rd;
    dcache_pkg::strb_t [dcache_pkg::NUM_WAYS-1:0]   data_be;
    dcache_pkg::line_t                              data_wdata;
    dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]   data_rd;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_ready_o     (cpu_ready_o),
        .cpu_resp_o      (cpu_resp_o),
        .mem_req_o       (mem_req_o),
        .mem_resp_i      (mem_resp_i),
        .index_o         (index),
        .tag_we_o        (tag_we),
        .tag_way_o       (tag_way),
        .tag_wtag_o      (tag_wtag),
        .tag_dirty_o     (tag_dirty),
        .lru_we_o        (lru_we),
        .lru_way_o       (lru_way),
        .tag_i           (tag_rd),
        .valid_i         (valid_rd),
        .dirty_i         (dirty_rd),
        .lru_i           (lru_rd),
        .data_be_o       (data_be),
        .data_wdata_o    (data_wdata),
        .data_rdata_i    (data_rd)
    );

    dcache_tag_store u_tag_store (
        .clk       (clk),
        .reset_i   (reset_i),
        .index_i   (index),
        .we_i      (tag_we),
        .way_i     (tag_way),
        .tag_i     (tag_wtag),
        .dirty_i   (tag_dirty),
        .lru_we_i  (lru_we),
        .lru_way_i (lru_way),
        .tag_o     (tag_rd),
        .valid_o   (valid_rd),
        .dirty_o   (dirty_rd),
        .lru_o     (lru_rd)
    );

    dcache_data_store u_data_store (
        .clk     (clk),
        .index_i (index),
        .be_i    (data_be),
        .wdata_i (data_wdata),
        .rdata_o (data_rd)
    );

endmodule

// ==== source/dcache_ctrl.sv ====
// Data cache controller
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                                             clk,
    input  logic                                             reset_i,
    // Processor side.
    input  logic                                             cpu_req_valid_i,
    input  dcache_pkg::cpu_req_t                             cpu_req_i,
    output logic                                             cpu_ready_o,
    output dcache_pkg::cpu_resp_t                            cpu_resp_o,
    // Memory side.
    output dcache_pkg::mem_req_t                             mem_req_o,
    input  dcache_pkg::mem_resp_t                            mem_resp_i,
    // Store access.
    output dcache_pkg::index_t                               index_o,
    output logic                                             tag_we_o,
    output dcache_pkg::way_t                                 tag_way_o,
    output dcache_pkg::tag_t                                 tag_wtag_o,
    output logic                                             tag_dirty_o,
    output logic                                             lru_we_o,
    output dcache_pkg::way_t                                 lru_way_o,
    input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0]      tag_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                  valid_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                  dirty_i,
    input  dcache_pkg::way_t                                 lru_i,
    output dcache_pkg::strb_t [dcache_pkg::NUM_WAYS-1:0]     data_be_o,
    output dcache_pkg::line_t                                data_wdata_o,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]     data_rdata_i
);

    dcache_pkg::cache_state_e state_q, state_d;
    dcache_pkg::cpu_req_t     req_q;
    dcache_pkg::addr_t        req_addr;
    dcache_pkg::addr_t        in_addr;

    logic [dcache_pkg::NUM_WAYS-1:0] hit_vec;
    logic                            hit;
    logic                            lookup_hit;
    logic                            write_hit;
    logic                            refill_done;
    dcache_pkg::way_t                hit_way;
    dcache_pkg::way_t                victim;
    dcache_pkg::way_t                victim_q;

    assign req_addr = dcache_pkg::addr_t'(req_q.addr);
    assign in_addr  = dcache_pkg::addr_t'(cpu_req_i.addr);

    // ************************************************************************
    // Lookup
    // ************************************************************************
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
            hit_vec[w] = valid_i[w] && (tag_i[w] == req_addr.tag);
    end

    assign hit         = |hit_vec;
    assign hit_way     = hit_vec[1];
    assign lookup_hit  = (state_q == dcache_pkg::ST_LOOKUP) && hit;
    assign write_hit   = lookup_hit && (req_q.op == dcache_pkg::OP_WRITE);
    assign refill_done = (state_q == dcache_pkg::ST_REFILL) && mem_resp_i.ready;

    // Prefer an empty way, then the older one.
    assign victim = !valid_i[0] ? 1'b0 :
                    !valid_i[1] ? 1'b1 : lru_i;

    assign index_o = (state_q == dcache_pkg::ST_IDLE) ? in_addr.index : req_addr.index;

    // ************************************************************************
    // State machine
    // ************************************************************************
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            dcache_pkg::ST_IDLE: begin
                if (cpu_req_valid_i)
                    state_d = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_LOOKUP: begin
                if (hit)
                    state_d = dcache_pkg::ST_IDLE;
                else if (valid_i[victim] && dirty_i[victim])
                    state_d = dcache_pkg::ST_WRITEBACK;
                else
                    state_d = dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_WRITEBACK: begin
                if (mem_resp_i.ready)
                    state_d = dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_REFILL: begin
                if (mem_resp_i.ready)
                    state_d = dcache_pkg::ST_LOOKUP; // Replays, now hits.
            end
            default: state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q  <= dcache_pkg::ST_IDLE;
            victim_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == dcache_pkg::ST_LOOKUP && !hit)
                victim_q <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid_i && cpu_ready_o)
            req_q <= cpu_req_i;
    end

    // ************************************************************************
    // Store writes and ports
    // ************************************************************************
    always_comb begin
        data_be_o    = '0;
        data_wdata_o = req_q.wdata;
        if (write_hit) begin
            data_be_o[hit_way] = req_q.strb;
        end else if (refill_done) begin
            data_be_o[victim_q] = '1; // Whole line.
            data_wdata_o        = mem_resp_i.rdata;
        end
    end

    assign tag_we_o    = write_hit || refill_done;
    assign tag_way_o   = write_hit ? hit_way : victim_q;
    assign tag_wtag_o  = req_addr.tag;
    assign tag_dirty_o = write_hit;
    assign lru_we_o    = lookup_hit;
    assign lru_way_o   = hit_way;

    assign cpu_ready_o      = (state_q == dcache_pkg::ST_IDLE);
    assign cpu_resp_o.valid = lookup_hit;
    assign cpu_resp_o.rdata = data_rdata_i[hit_way];

    always_comb begin
        dcache_pkg::addr_t line_addr;
        line_addr        = req_addr;
        line_addr.offset = '0;
        mem_req_o.cmd    = dcache_pkg::MEM_NONE;
        mem_req_o.wdata  = '0;
        if (state_q == dcache_pkg::ST_WRITEBACK) begin
            line_addr.tag   = tag_i[victim_q]; // Victim's own line.
            mem_req_o.cmd   = dcache_pkg::MEM_WRITEBACK;
            mem_req_o.wdata = data_rdata_i[victim_q];
        end else if (state_q == dcache_pkg::ST_REFILL) begin
            mem_req_o.cmd = dcache_pkg::MEM_REFILL;
        end
        mem_req_o.addr = line_addr;
    end

    mem_req_stable_a : assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o.cmd != dcache_pkg::MEM_NONE && !mem_resp_i.ready) |=> $stable(mem_req_o))
        else $error("Memory request changed while waiting for ready.");

endmodule

// ==== source/dcache_data_store.sv ====
// Cache line data store
`timescale 1ns/1ns

module dcache_data_store (
    input  logic                                             clk,
    input  dcache_pkg::index_t                               index_i,
    input  dcache_pkg::strb_t [dcache_pkg::NUM_WAYS-1:0]     be_i,
    input  dcache_pkg::line_t                                wdata_i,
    output dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]     rdata_o
);

    localparam int BW = dcache_pkg::BYTE_W;

    dcache_pkg::line_t line_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

    // Byte-enabled write, registered read of the addressed set.
    always_ff @(posedge clk) begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (be_i[w][b]) begin
                    line_mem[w][index_i][b*BW +: BW] <= wdata_i[b*BW +: BW];
                    rdata_o[w][b*BW +: BW]           <= wdata_i[b*BW +: BW]; // Forward.
                end else begin
                    rdata_o[w][b*BW +: BW] <= line_mem[w][index_i][b*BW +: BW];
                end
            end
        end
    end

endmodule

// ==== source/dcache_tag_store.sv ====
// Tag, valid, dirty and LRU store
`timescale 1ns/1ns

module dcache_tag_store (
    input  logic                                                clk,
    input  logic                                                reset_i,
    input  dcache_pkg::index_t                                  index_i,
    input  logic                                                we_i,
    input  dcache_pkg::way_t                                    way_i,
    input  dcache_pkg::tag_t                                    tag_i,
    input  logic                                                dirty_i,
    input  logic                                                lru_we_i,
    input  dcache_pkg::way_t                                    lru_way_i,
    output dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0]         tag_o,
    output logic [dcache_pkg::NUM_WAYS-1:0]                     valid_o,
    output logic [dcache_pkg::NUM_WAYS-1:0]                     dirty_o,
    output dcache_pkg::way_t                                    lru_o
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic             dirty_mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] valid_q;
    dcache_pkg::way_t [dcache_pkg::NUM_SETS-1:0]               lru_q;

    // Control bits, cleared by reset. Reads forward a same-edge write.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            lru_q   <= '0;
            valid_o <= '0;
            lru_o   <= '0;
        end else begin
            if (we_i)
                valid_q[way_i][index_i] <= 1'b1;
            if (lru_we_i)
                lru_q[index_i] <= ~lru_way_i; // Other way is now oldest.
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++)
                valid_o[w] <= valid_q[w][index_i] | (we_i && way_i == dcache_pkg::way_t'(w));
            lru_o <= lru_we_i ? ~lru_way_i : lru_q[index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[way_i][index_i]   <= tag_i;
            dirty_mem[way_i][index_i] <= dirty_i;
        end
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (we_i && way_i == dcache_pkg::way_t'(w)) begin
                tag_o[w]   <= tag_i;
                dirty_o[w] <= dirty_i;
            end else begin
                tag_o[w]   <= tag_mem[w][index_i];
                dirty_o[w] <= dirty_mem[w][index_i];
            end
        end
    end

    // A line lives in at most one way of its set.
    no_duplicate_tag_a : assert property (@(posedge clk) disable iff (reset_i)
        !(valid_o[0] && valid_o[1] && tag_o[0] == tag_o[1]))
        else $error("Both ways of a set hold the same valid tag.");

endmodule

// ==== source/dcache_pkg.sv ====
// Data cache shared definitions
package dcache_pkg;

    // ************************************************************************
    // Geometry
    // ************************************************************************
    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 55 bits.
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int NUM_WAYS = 2;
    localparam int BYTE_W   = DATA_W / STRB_W;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [DATA_W-1:0]  line_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic               way_t;

    // Address split, most significant field first.
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } addr_t;

    // ************************************************************************
    // Encodings
    // ************************************************************************
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cpu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITEBACK,
        MEM_REFILL
    } mem_cmd_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } cache_state_e;

    // ************************************************************************
    // Port bundles
    // ************************************************************************
    typedef struct packed {
        cpu_op_e           op;
        logic [ADDR_W-1:0] addr;
        line_t             wdata;
        strb_t             strb;
    } cpu_req_t;

    typedef struct packed {
        logic  valid; // One-cycle completion strobe.
        line_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        mem_cmd_e          cmd;
        logic [ADDR_W-1:0] addr; // Line address, offset zero.
        line_t             wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        line_t rdata;
    } mem_resp_t;

endpackage
